// ==== verilog.f ====
src/sync_aggr_pkg.sv
src/sync_aggr_ctrl_pkg.sv
src/pipe_fifo.sv
src/timestamp_align_determination.sv
src/aggr_emit_ctrl.sv
src/sync_aggr_top.sv
dv/sync_aggr_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = sync_aggr_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/sync_aggr_tb.sv ====
// ==============================
// Aggregator testbench with random traffic,
// per-pipe queue model and credit model
// ==============================
`timescale 1ns/1ps
`default_nettype none

module sync_aggr_tb
    import sync_aggr_pkg::*;
    import sync_aggr_ctrl_pkg::*;
();

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [NUM_PIPES-1:0] pipe_wr_en;
    logic [PKT_W-1:0]     wr_data [NUM_PIPES];
    logic [NUM_PIPES-1:0] normal_map;
    logic [NUM_PIPES-1:0] restart_map;
    logic [THRESH_W-1:0]  threshold;
    logic [TS_W-1:0]      local_ts = TS_W'(64'h1_0000_0000);
    logic                 credit_return = 1'b0;
    logic [NUM_PIPES-1:0] pipe_full;
    logic                 out_vld;
    logic [PIPE_ID_W-1:0] out_pipe;
    logic [PKT_W-1:0]     out_data;

    // Model state
    logic [PKT_W-1:0]     model_q [NUM_PIPES][$];
    logic [PIPE_ID_W-1:0] emit_pipes [$];
    int                   emit_cycles [$];
    int                   tb_credits = int'(CREDIT_MAX);
    int                   sent_cnt = 0;
    int                   returned_cnt = 0;
    int                   cycle_cnt = 0;
    int                   seq_num = 0;
    int                   err_count = 0;
    int                   timeout_count = 0;
    logic                 return_en = 1'b0;

    sync_aggr_top sync_aggr_top_inst (
        .clk(clk), .rst_n(rst_n), .pipe_wr_en(pipe_wr_en),
        .pipe_wr_data_0(wr_data[0]), .pipe_wr_data_1(wr_data[1]),
        .pipe_wr_data_2(wr_data[2]), .pipe_wr_data_3(wr_data[3]),
        .pipe_normal_bitmap(normal_map), .pipe_restart_bitmap(restart_map),
        .timeout_threshold(threshold), .local_timestamp(local_ts),
        .credit_return(credit_return), .pipe_full(pipe_full),
        .out_vld(out_vld), .out_pipe(out_pipe), .out_data(out_data));

    always #20 clk = ~clk;

    // Free-running local time
    always @(posedge clk) begin
        local_ts <= local_ts + 1'b1;
    end

    // Consumer hands back spent credits after a random delay
    always @(posedge clk) begin
        if (!rst_n) begin
            credit_return <= 1'b0;
        end else if (return_en && (returned_cnt < sent_cnt) && ($urandom_range(0, 3) == 0)) begin
            credit_return <= 1'b1;
            returned_cnt  <= returned_cnt + 1;
        end else begin
            credit_return <= 1'b0;
        end
    end

    // ==============================
    // Monitor, sampled mid-cycle
    // ==============================
    always @(negedge clk) begin
        logic [NUM_PIPES-1:0] checked;
        checked = normal_map | restart_map;
        if (rst_n) begin
            cycle_cnt++;
            for (int i = 0; i < NUM_PIPES; i++) begin
                assert (pipe_full[i] == (model_q[i].size() == FIFO_DEPTH)) else begin
                    $display("** Error at %0t: pipe %0d full flag is %b", $time, i, pipe_full[i]);
                    err_count++;
                end
            end
            if (out_vld) begin
                assert (tb_credits != 0) else begin
                    $display("** Error at %0t: out_vld with no credit left", $time);
                    err_count++;
                end
                assert (checked[out_pipe]) else begin
                    $display("** Error at %0t: unchecked pipe %0d emitted", $time, out_pipe);
                    err_count++;
                end
                assert (model_q[out_pipe].size() != 0) else begin
                    $display("** Error at %0t: pipe %0d emitted while empty", $time, out_pipe);
                    err_count++;
                end
                if (model_q[out_pipe].size() != 0) begin
                    assert (out_data == model_q[out_pipe][0]) else begin
                        $display("** Error at %0t: pipe %0d data %h, expected %h", $time,
                                 out_pipe, out_data, model_q[out_pipe][0]);
                        err_count++;
                    end
                    void'(model_q[out_pipe].pop_front());
                end
                tb_credits--;
                sent_cnt++;
                emit_pipes.push_back(out_pipe);
                emit_cycles.push_back(cycle_cnt);
            end
            if (credit_return) begin
                tb_credits++;
            end
            // Writes land after the pop check
            for (int i = 0; i < NUM_PIPES; i++) begin
                if (pipe_wr_en[i]) begin
                    model_q[i].push_back(wr_data[i]);
                end
            end
        end
    end

    // Payload carries pipe tag and sequence number
    function automatic logic [PKT_W-1:0] make_pkt(input int pipe, input int seq,
                                                  input logic [TS_W-1:0] ts);
        return {PIPE_ID_W'(pipe), (PAYLOAD_W - PIPE_ID_W)'(seq), ts};
    endfunction

    function automatic logic [TS_W-1:0] random_ts();
        return TS_W'({$urandom(), $urandom(), $urandom()});
    endfunction

    // One write cycle on the masked pipes, same timestamp
    task automatic write_pipes(input logic [NUM_PIPES-1:0] mask, input logic [TS_W-1:0] ts);
        @(posedge clk);
        for (int i = 0; i < NUM_PIPES; i++) begin
            wr_data[i] <= make_pkt(i, seq_num, ts);
        end
        seq_num++;
        pipe_wr_en <= mask;
        @(posedge clk);
        pipe_wr_en <= '0;
    endtask

    // Random writes, never into a full FIFO
    task automatic random_traffic(input int n_cycles);
        logic [NUM_PIPES-1:0] mask;
        for (int c = 0; c < n_cycles; c++) begin
            @(posedge clk);
            mask = '0;
            for (int i = 0; i < NUM_PIPES; i++) begin
                if ((model_q[i].size() < FIFO_DEPTH) && ($urandom_range(0, 2) == 0)) begin
                    mask[i] = 1'b1;
                end
                wr_data[i] <= make_pkt(i, seq_num, random_ts());
            end
            seq_num++;
            pipe_wr_en <= mask;
        end
        @(posedge clk);
        pipe_wr_en <= '0;
    endtask

    task automatic wait_drained(input logic [NUM_PIPES-1:0] mask, input int limit,
                                input string what);
        int   n;
        logic busy;
        n    = 0;
        busy = 1'b1;
        while (busy && (n < limit)) begin
            @(posedge clk);
            n++;
            busy = 1'b0;
            for (int i = 0; i < NUM_PIPES; i++) begin
                if (mask[i] && (model_q[i].size() != 0)) begin
                    busy = 1'b1;
                end
            end
        end
        if (busy) begin
            $display("Timeout: queues of %s did not drain in %0d cycles", what, limit);
            timeout_count++;
        end
    endtask

    task automatic wait_emitted(input int target, input int limit, input string what);
        int n;
        n = 0;
        while ((emit_pipes.size() < target) && (n < limit)) begin
            @(posedge clk);
            n++;
        end
        if (emit_pipes.size() < target) begin
            $display("Timeout: %s produced too few packets in %0d cycles", what, limit);
            timeout_count++;
        end
    endtask

    task automatic wait_credits(input int limit);
        int n;
        n = 0;
        while ((tb_credits != int'(CREDIT_MAX)) && (n < limit)) begin
            @(posedge clk);
            n++;
        end
        if (tb_credits != int'(CREDIT_MAX)) begin
            $display("Timeout: credits were not returned within %0d cycles", limit);
            timeout_count++;
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        logic [NUM_PIPES-1:0] nm;
        logic [NUM_PIPES-1:0] rm;
        int                   base;
        void'($urandom(86119));
        rst_n       = 1'b0;
        pipe_wr_en  = '0;
        normal_map  = '0;
        restart_map = '0;
        threshold   = '0;
        for (int i = 0; i < NUM_PIPES; i++) begin
            wr_data[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!out_vld && (pipe_full == '0)) else begin
            $display("** Error at %0t: outputs not idle after reset", $time);
            err_count++;
        end

        // Initial credits only, output stops after CREDIT_MAX packets
        @(posedge clk);
        normal_map <= '1;
        base = emit_pipes.size();
        write_pipes('1, random_ts());
        write_pipes('1, random_ts());
        repeat (200) @(posedge clk);
        assert ((emit_pipes.size() - base) == int'(CREDIT_MAX)) else begin
            $display("** Error at %0t: %0d packets sent without returns, expected %0d", $time,
                     emit_pipes.size() - base, CREDIT_MAX);
            err_count++;
        end
        return_en <= 1'b1;
        wait_drained('1, 500, "credit stall phase");

        // Random bitmaps and traffic, zero threshold
        for (int r = 0; r < 12; r++) begin
            nm = NUM_PIPES'($urandom());
            rm = NUM_PIPES'($urandom()) & NUM_PIPES'($urandom());
            @(posedge clk);
            normal_map  <= nm;
            restart_map <= rm;
            random_traffic(60);
            wait_drained(nm | rm, 1000, "random phase");
        end

        // Pipe 2 left unchecked fills and stays full
        @(posedge clk);
        normal_map  <= '1;
        restart_map <= '0;
        wait_drained('1, 1000, "pre-exclusion drain");
        @(posedge clk);
        normal_map  <= 4'b1011;
        restart_map <= 4'b0001;
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            write_pipes(4'b0100, random_ts());
        end
        random_traffic(40);
        wait_drained(4'b1011, 1000, "exclusion phase");
        @(negedge clk);
        assert ((model_q[2].size() == FIFO_DEPTH) && pipe_full[2]) else begin
            $display("** Error at %0t: excluded pipe 2 holds %0d packets", $time,
                     model_q[2].size());
            err_count++;
        end

        // Full alignment round with a large threshold
        @(posedge clk);
        normal_map  <= '1;
        restart_map <= '0;
        wait_drained('1, 1000, "pipe 2 release");
        @(posedge clk);
        threshold <= '1;
        wait_credits(500);
        base = emit_pipes.size();
        write_pipes('1, local_ts);
        wait_emitted(base + NUM_PIPES, 200, "full alignment");
        if (emit_pipes.size() >= base + NUM_PIPES) begin
            for (int k = 0; k < NUM_PIPES; k++) begin
                assert ((emit_pipes[base + k] == PIPE_ID_W'(k)) &&
                        (emit_cycles[base + k] == emit_cycles[base] + k)) else begin
                    $display("** Error at %0t: round slot %0d carried pipe %0d", $time, k,
                             emit_pipes[base + k]);
                    err_count++;
                end
            end
        end

        // Stale head on pipe 0 times out alone
        @(posedge clk);
        threshold <= 20'd1000;
        base = emit_pipes.size();
        write_pipes(4'b0001, local_ts - TS_W'(5000));
        wait_emitted(base + 1, 200, "timeout round");
        if (emit_pipes.size() > base) begin
            assert (emit_pipes[base] == '0) else begin
                $display("** Error at %0t: timeout round emitted pipe %0d", $time,
                         emit_pipes[base]);
                err_count++;
            end
        end

        // Recent head must wait
        base = emit_pipes.size();
        write_pipes(4'b0001, local_ts);
        repeat (100) @(posedge clk);
        assert (emit_pipes.size() == base) else begin
            $display("** Error at %0t: recent head emitted before timeout", $time);
            err_count++;
        end
        @(posedge clk);
        threshold <= '0;
        wait_drained('1, 1000, "final drain");

        $display("Checks done: %0d errors, %0d timeouts, %0d packets", err_count,
                 timeout_count, emit_pipes.size());
        if ((err_count == 0) && (timeout_count == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/sync_aggr_top.sv ====
// ============================
// Aggregator top, four pipe
// FIFOs, alignment and emit FSM
// ============================
`timescale 1ns/1ps
`default_nettype none

module sync_aggr_top
    import sync_aggr_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic [NUM_PIPES-1:0] pipe_wr_en,
    input  wire logic [PKT_W-1:0]     pipe_wr_data_0,
    input  wire logic [PKT_W-1:0]     pipe_wr_data_1,
    input  wire logic [PKT_W-1:0]     pipe_wr_data_2,
    input  wire logic [PKT_W-1:0]     pipe_wr_data_3,
    input  wire logic [NUM_PIPES-1:0] pipe_normal_bitmap,
    input  wire logic [NUM_PIPES-1:0] pipe_restart_bitmap,
    input  wire logic [THRESH_W-1:0]  timeout_threshold,
    input  wire logic [TS_W-1:0]      local_timestamp,
    input  wire logic                 credit_return,
    output logic      [NUM_PIPES-1:0] pipe_full,
    output logic                      out_vld,
    output logic      [PIPE_ID_W-1:0] out_pipe,
    output logic      [PKT_W-1:0]     out_data
);

    logic [NUM_PIPES-1:0] head_vld;
    logic [PKT_W-1:0]     head_data_0, head_data_1, head_data_2, head_data_3;
    logic [NUM_PIPES-1:0] pop;
    logic                 start_align;
    logic                 align_pass;
    logic [NUM_PIPES-1:0] align_pass_bitmap;

    // Input pipes
    pipe_fifo fifo_0_inst (.clk(clk), .rst_n(rst_n), .wr_en(pipe_wr_en[0]),
        .wr_data(pipe_wr_data_0), .rd_en(pop[0]), .full(pipe_full[0]),
        .head_vld(head_vld[0]), .head_data(head_data_0));
    pipe_fifo fifo_1_inst (.clk(clk), .rst_n(rst_n), .wr_en(pipe_wr_en[1]),
        .wr_data(pipe_wr_data_1), .rd_en(pop[1]), .full(pipe_full[1]),
        .head_vld(head_vld[1]), .head_data(head_data_1));
    pipe_fifo fifo_2_inst (.clk(clk), .rst_n(rst_n), .wr_en(pipe_wr_en[2]),
        .wr_data(pipe_wr_data_2), .rd_en(pop[2]), .full(pipe_full[2]),
        .head_vld(head_vld[2]), .head_data(head_data_2));
    pipe_fifo fifo_3_inst (.clk(clk), .rst_n(rst_n), .wr_en(pipe_wr_en[3]),
        .wr_data(pipe_wr_data_3), .rd_en(pop[3]), .full(pipe_full[3]),
        .head_vld(head_vld[3]), .head_data(head_data_3));

    // Verdict from the same heads the controller pops
    timestamp_align_determination align_inst (
        .clk(clk), .rst_n(rst_n), .timeout_threshold(timeout_threshold),
        .pipe_normal_bitmap(pipe_normal_bitmap), .pipe_restart_bitmap(pipe_restart_bitmap),
        .head_vld(head_vld), .head_data_0(head_data_0), .head_data_1(head_data_1),
        .head_data_2(head_data_2), .head_data_3(head_data_3),
        .local_timestamp(local_timestamp), .start_timestamp_align(start_align),
        .timestamp_align_pass(align_pass), .timestamp_align_fail(),
        .timestamp_align_pass_bitmap(align_pass_bitmap));

    aggr_emit_ctrl emit_inst (
        .clk(clk), .rst_n(rst_n), .head_vld(head_vld),
        .head_data_0(head_data_0), .head_data_1(head_data_1),
        .head_data_2(head_data_2), .head_data_3(head_data_3),
        .timestamp_align_pass(align_pass), .timestamp_align_pass_bitmap(align_pass_bitmap),
        .credit_return(credit_return), .start_timestamp_align(start_align), .pop(pop),
        .out_vld(out_vld), .out_pipe(out_pipe), .out_data(out_data));

endmodule

`default_nettype wire

// ==== src/aggr_emit_ctrl.sv ====
// ============================
// Round FSM, in-order pops and
// output credit counter
// ============================
`timescale 1ns/1ps
`default_nettype none

module aggr_emit_ctrl
    import sync_aggr_pkg::*;
    import sync_aggr_ctrl_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic [NUM_PIPES-1:0] head_vld,
    input  wire logic [PKT_W-1:0]     head_data_0,
    input  wire logic [PKT_W-1:0]     head_data_1,
    input  wire logic [PKT_W-1:0]     head_data_2,
    input  wire logic [PKT_W-1:0]     head_data_3,
    input  wire logic                 timestamp_align_pass,
    input  wire logic [NUM_PIPES-1:0] timestamp_align_pass_bitmap,
    input  wire logic                 credit_return,
    output logic                      start_timestamp_align,
    output logic      [NUM_PIPES-1:0] pop,
    output logic                      out_vld,
    output logic      [PIPE_ID_W-1:0] out_pipe,
    output logic      [PKT_W-1:0]     out_data
);

    aggr_state_e                state;
    logic [$bits(ALIGN_LAT)-1:0] lat_cnt;
    logic [NUM_PIPES-1:0]        emit_map;
    logic [NUM_PIPES-1:0]        emit_map_nxt;
    logic [PIPE_ID_W-1:0]        sel_idx;
    logic [CREDIT_W-1:0]         credit_cnt;

    // Lowest pipe still waiting in this round
    always_comb begin
        sel_idx = '0;
        for (int i = NUM_PIPES - 1; i >= 0; i--) begin
            if (emit_map[i]) begin
                sel_idx = PIPE_ID_W'(i);
            end
        end
    end

    // One packet per cycle while credits last
    assign out_vld  = (state == EMIT) && (emit_map != '0) && (credit_cnt != '0);
    assign out_pipe = sel_idx;
    assign pop      = out_vld ? (NUM_PIPES'(1) << sel_idx) : '0;
    assign emit_map_nxt = emit_map & ~pop;

    // Head mux for the selected pipe
    always_comb begin
        case (sel_idx)
            2'd0:    out_data = head_data_0;
            2'd1:    out_data = head_data_1;
            2'd2:    out_data = head_data_2;
            default: out_data = head_data_3;
        endcase
    end

    // ==============================
    // Round FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state                 <= IDLE;
            start_timestamp_align <= 1'b0;
            lat_cnt               <= '0;
            emit_map              <= '0;
        end else begin
            start_timestamp_align <= 1'b0;
            case (state)
                IDLE: begin
                    // Start pulse goes out with the first ALIGN_WAIT cycle
                    start_timestamp_align <= 1'b1;
                    lat_cnt               <= '0;
                    state                 <= ALIGN_WAIT;
                end
                ALIGN_WAIT: begin
                    if (lat_cnt == ALIGN_LAT) begin
                        // Verdict cycle
                        if (timestamp_align_pass && (timestamp_align_pass_bitmap != '0)) begin
                            emit_map <= timestamp_align_pass_bitmap;
                            state    <= EMIT;
                        end else begin
                            state <= IDLE;
                        end
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                EMIT: begin
                    emit_map <= emit_map_nxt;
                    // Round ends with the last pop
                    if (emit_map_nxt == '0) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Output credits, one spent per out_vld
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CREDIT_MAX;
        end else begin
            case ({out_vld, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Consumer returns no more than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= CREDIT_MAX);
    a_no_vld_wo_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_vld |-> (credit_cnt != '0) && head_vld[out_pipe]);

endmodule

`default_nettype wire

// ==== src/timestamp_align_determination.sv ====
// ============================
// Three-stage oldest-timestamp
// and timeout check, pass bitmap
// ============================
`timescale 1ns/1ps
`default_nettype none

module timestamp_align_determination
    import sync_aggr_pkg::*;
    import sync_aggr_ctrl_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic [THRESH_W-1:0]  timeout_threshold,
    input  wire logic [NUM_PIPES-1:0] pipe_normal_bitmap,
    input  wire logic [NUM_PIPES-1:0] pipe_restart_bitmap,
    input  wire logic [NUM_PIPES-1:0] head_vld,
    input  wire logic [PKT_W-1:0]     head_data_0,
    input  wire logic [PKT_W-1:0]     head_data_1,
    input  wire logic [PKT_W-1:0]     head_data_2,
    input  wire logic [PKT_W-1:0]     head_data_3,
    input  wire logic [TS_W-1:0]      local_timestamp,
    input  wire logic                 start_timestamp_align,
    output logic                      timestamp_align_pass,
    output logic                      timestamp_align_fail,
    output logic      [NUM_PIPES-1:0] timestamp_align_pass_bitmap
);

    // Smaller of two timestamps, an invalid side counts as TS_MAX
    function automatic logic [TS_W-1:0] pair_min(
        input logic            vld_a,
        input logic [TS_W-1:0] ts_a,
        input logic            vld_b,
        input logic [TS_W-1:0] ts_b
    );
        logic [TS_W-1:0] a_eff;
        logic [TS_W-1:0] b_eff;
        a_eff = vld_a ? ts_a : TS_MAX;
        b_eff = vld_b ? ts_b : TS_MAX;
        return (a_eff < b_eff) ? a_eff : b_eff;
    endfunction

    logic [NUM_PIPES-1:0] check_map;
    logic [NUM_PIPES-1:0] ready_map;
    logic [TS_W-1:0]      s2_offset;

    // Stage registers
    logic                 s1_vld, s2_vld, s3_vld;
    logic [NUM_PIPES-1:0] s1_check, s2_check, s3_check;
    logic [NUM_PIPES-1:0] s1_ready, s2_ready, s3_ready;
    logic                 s1_all_rdy, s2_all_rdy, s3_all_rdy;
    logic [TS_W-1:0]      s1_min01, s1_min23;
    logic [TS_W-1:0]      s1_local, s2_local;
    logic [THRESH_W-1:0]  s1_thresh, s2_thresh;
    logic [TS_W-1:0]      s2_oldest;
    logic                 s3_timeout;

    // Checked pipes and those with a head
    assign check_map = pipe_normal_bitmap | pipe_restart_bitmap;
    assign ready_map = check_map & head_vld;

    // Age of the oldest head, wraps modulo 2^TS_W
    assign s2_offset = s2_local - s2_oldest;

    // Valid chain, one start accepted per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
            s3_vld <= 1'b0;
        end else begin
            s1_vld <= start_timestamp_align;
            s2_vld <= s1_vld;
            s3_vld <= s2_vld;
        end
    end

    // ==============================
    // Stage 1, pairwise minima
    // ==============================
    always_ff @(posedge clk) begin
        if (start_timestamp_align) begin
            s1_check   <= check_map;
            s1_ready   <= ready_map;
            s1_all_rdy <= (ready_map == check_map);
            s1_min01   <= pair_min(ready_map[0], head_data_0[TS_W-1:0],
                                   ready_map[1], head_data_1[TS_W-1:0]);
            s1_min23   <= pair_min(ready_map[2], head_data_2[TS_W-1:0],
                                   ready_map[3], head_data_3[TS_W-1:0]);
            s1_local   <= local_timestamp;
            s1_thresh  <= timeout_threshold;
        end
    end

    // ==============================
    // Stage 2, overall oldest head
    // ==============================
    always_ff @(posedge clk) begin
        if (s1_vld) begin
            s2_check   <= s1_check;
            s2_ready   <= s1_ready;
            s2_all_rdy <= s1_all_rdy;
            s2_oldest  <= pair_min(1'b1, s1_min01, 1'b1, s1_min23);
            s2_local   <= s1_local;
            s2_thresh  <= s1_thresh;
        end
    end

    // ==============================
    // Stage 3, timeout against threshold
    // ==============================
    always_ff @(posedge clk) begin
        if (s2_vld) begin
            s3_check   <= s2_check;
            s3_ready   <= s2_ready;
            s3_all_rdy <= s2_all_rdy;
            s3_timeout <= (s2_offset >= TS_W'(s2_thresh));
        end
    end

    // Verdict register, idle value is fail with an empty bitmap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timestamp_align_pass        <= 1'b0;
            timestamp_align_fail        <= 1'b1;
            timestamp_align_pass_bitmap <= '0;
        end else if (s3_vld && s3_all_rdy) begin
            // Every checked pipe has data
            timestamp_align_pass        <= 1'b1;
            timestamp_align_fail        <= 1'b0;
            timestamp_align_pass_bitmap <= s3_check;
        end else if (s3_vld && s3_timeout) begin
            // Oldest head waited long enough, serve what is there
            timestamp_align_pass        <= 1'b1;
            timestamp_align_fail        <= 1'b0;
            timestamp_align_pass_bitmap <= s3_ready;
        end else begin
            timestamp_align_pass        <= 1'b0;
            timestamp_align_fail        <= 1'b1;
            timestamp_align_pass_bitmap <= '0;
        end
    end

    a_verdict_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(timestamp_align_pass && timestamp_align_fail));

endmodule

`default_nettype wire

// ==== src/pipe_fifo.sv ====
// ============================
// First-word-fall-through FIFO
// for one input pipe
// ============================
`timescale 1ns/1ps
`default_nettype none

module pipe_fifo
    import sync_aggr_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             wr_en,
    input  wire logic [PKT_W-1:0] wr_data,
    input  wire logic             rd_en,
    output logic                  full,
    output logic                  head_vld,
    output logic      [PKT_W-1:0] head_data
);

    logic [PKT_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               wr_ok;
    logic               rd_ok;

    // Drop writes when full, ignore reads when empty
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && head_vld;

    assign full      = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign head_vld  = (count != '0);
    // Head falls through from the read pointer
    assign head_data = mem[rd_ptr];

    // Pointers wrap at the power-of-two depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Writer must honour full, reader must honour head_vld
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> head_vld);

endmodule

`default_nettype wire

// ==== src/sync_aggr_ctrl_pkg.sv ====
// ============================
// Emit FSM states, alignment
// latency and output credits
// ============================
`default_nettype none

package sync_aggr_ctrl_pkg;

    // Emit controller states
    typedef enum logic [1:0] {
        IDLE,
        ALIGN_WAIT,
        EMIT
    } aggr_state_e;

    // Start cycle to verdict cycle
    localparam logic [2:0] ALIGN_LAT = 3'd4;

    // Output credit counter
    localparam int CREDIT_W = 3;
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = 3'd4;

endpackage

`default_nettype wire

// ==== src/sync_aggr_pkg.sv ====
// ============================
// Packet layout, pipe count and
// per-pipe FIFO sizing
// ============================
`default_nettype none

package sync_aggr_pkg;

    // Number of input pipes
    localparam int NUM_PIPES = 4;
    localparam int PIPE_ID_W = 2;

    // Packet fields, timestamp in the low bits
    localparam int TS_W      = 80;
    localparam int PAYLOAD_W = 22;
    localparam int PKT_W     = PAYLOAD_W + TS_W;

    // Timeout threshold width
    localparam int THRESH_W = 20;

    // Per-pipe FIFO
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    // Marks an empty head in the min search
    localparam logic [TS_W-1:0] TS_MAX = '1;

endpackage

`default_nettype wire
